/* compile.f */
+incdir+hw
hw/cache_pkg.sv
hw/cache_req_if.sv
hw/request_arbiter.sv
hw/request_decode.sv
hw/sync_fifo.sv
hw/cache_bus_master.sv
hw/response_router.sv
hw/cache_request_generator.sv
testbench/tb_cache_request_generator.sv

/* Makefile */
# Verilator simulation of the cache request generator

VERILATOR ?= verilator
TOP       ?= tb_cache_request_generator
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -j 0

.PHONY: sim clean

# Exit status of the simulation binary is the pass or fail result
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* testbench/tb_cache_request_generator.sv */
`timescale 1ns/1ps
`include "cache_config.svh"

module tb_cache_request_generator;

  localparam int NUM_REQ = `CACHE_NUM_REQ;
  // Requests issued over all tests, worst case
  localparam int TOTAL_REQS = 70;
  localparam int TIMEOUT_CYCLES = 4 * TOTAL_REQS * 8;

  logic                                          ap_clk;
  logic                                          control_areset;
  logic                                          descriptor_valid;
  cache_pkg::buffer_bases                        descriptor_bases;
  logic [NUM_REQ-1:0]                            req_valid = '0;
  logic [NUM_REQ-1:0]                            req_write = '0;
  logic [NUM_REQ-1:0][`CACHE_BUF_W-1:0]          req_buffer = '0;
  logic [NUM_REQ-1:0][`CACHE_IDX_W-1:0]          req_index = '0;
  logic [NUM_REQ-1:0][`CACHE_DATA_W-1:0]         req_data = '0;
  logic [NUM_REQ-1:0]                            req_ready;
  logic [NUM_REQ-1:0]                            resp_valid;
  logic [`CACHE_DATA_W-1:0]                      resp_data;
  logic                                          wb_cyc;
  logic                                          wb_stb;
  logic                                          wb_we;
  logic [`CACHE_ADDR_W-1:0]                      wb_adr;
  logic [`CACHE_DATA_W-1:0]                      wb_dat_w;
  logic [`CACHE_DATA_W/8-1:0]                    wb_sel;
  logic [`CACHE_DATA_W-1:0]                      wb_dat_r = '0;
  logic                                          wb_ack = 1'b0;

  // Stimulus per engine and what the DUT owes back
  cache_pkg::engine_request  stim_q [NUM_REQ][$];
  cache_pkg::engine_request  cur_item [NUM_REQ];
  cache_pkg::cache_response  exp_q [NUM_REQ][$];
  cache_pkg::cache_request   exp_bus_q [$];
  cache_pkg::req_id_t        accept_log [$];
  // Owners of outstanding requests, oldest first
  cache_pkg::req_id_t        resp_order_q [$];
  cache_pkg::buffer_bases    bases_ref;
  logic [`CACHE_DATA_W-1:0]  ref_mem [logic [`CACHE_ADDR_W-3:0]];
  logic [`CACHE_DATA_W-1:0]  cache_mem [logic [`CACHE_ADDR_W-3:0]];
  string                     cur_test = "reset";
  int                        error_count = 0;
  int                        cycle_count = 0;
  int                        wait_left = 0;

  cache_request_generator uut (
    .ap_clk           (ap_clk),
    .control_areset   (control_areset),
    .descriptor_valid (descriptor_valid),
    .descriptor_bases (descriptor_bases),
    .req_valid        (req_valid),
    .req_write        (req_write),
    .req_buffer       (req_buffer),
    .req_index        (req_index),
    .req_data         (req_data),
    .req_ready        (req_ready),
    .resp_valid       (resp_valid),
    .resp_data        (resp_data),
    .wb_cyc           (wb_cyc),
    .wb_stb           (wb_stb),
    .wb_we            (wb_we),
    .wb_adr           (wb_adr),
    .wb_dat_w         (wb_dat_w),
    .wb_sel           (wb_sel),
    .wb_dat_r         (wb_dat_r),
    .wb_ack           (wb_ack)
  );

  initial begin
    ap_clk = 1'b0;
    forever #10 ap_clk = ~ap_clk;
  end

  // ------------------------------
  // Reporting and compares
  // ------------------------------
  task automatic report_failure(input string line);
    error_count = error_count + 1;
    $display("%s", line);
    $display("SIMULATION FAILED");
    $fatal(1, "stopping at first error");
  endtask

  // Write flag is not visible at the engine ports
  task automatic compare_response(input string test, input cache_pkg::cache_response exp,
                                  input cache_pkg::cache_response act);
    if (act.data !== exp.data || act.id !== exp.id) begin
      report_failure($sformatf("MISMATCH %s expected data=%h id=%0d actual data=%h id=%0d",
                               test, exp.data, exp.id, act.data, act.id));
    end
  endtask

  task automatic compare_address(input string test, input logic [`CACHE_ADDR_W-1:0] exp,
                                 input logic [`CACHE_ADDR_W-1:0] act);
    if (act !== exp) begin
      report_failure($sformatf("MISMATCH %s expected addr=%h actual addr=%h", test, exp, act));
    end
  endtask

  task automatic compare_write_data(input string test, input cache_pkg::data_t exp,
                                    input cache_pkg::data_t act);
    if (act !== exp) begin
      report_failure($sformatf("MISMATCH %s expected wdata=%h actual wdata=%h",
                               test, exp, act));
    end
  endtask

  task automatic compare_owner(input string test, input cache_pkg::req_id_t exp,
                               input cache_pkg::req_id_t act);
    if (act !== exp) begin
      report_failure($sformatf("MISMATCH %s expected engine=%0d actual engine=%0d",
                               test, exp, act));
    end
  endtask

  // Unwritten words, pattern over the whole word address
  function automatic logic [`CACHE_DATA_W-1:0] fill_word(input logic [`CACHE_ADDR_W-3:0] wa);
    return {2'b10, wa} ^ {wa[15:0], wa[29:14]};
  endfunction

  function automatic cache_pkg::engine_request make_req(input logic write,
      input cache_pkg::buf_sel_t buf_sel, input cache_pkg::index_t index,
      input cache_pkg::data_t data);
    cache_pkg::engine_request r;
    r.write   = write;
    r.buf_sel = buf_sel;
    r.index   = index;
    r.data    = data;
    r.id      = '0;
    return r;
  endfunction

  // ------------------------------
  // Reference model at acceptance
  // ------------------------------
  task automatic record_accept(input int e, input cache_pkg::engine_request item);
    cache_pkg::cache_request  bus_req;
    cache_pkg::cache_response resp;
    logic [`CACHE_ADDR_W-3:0] word;
    // Base plus four times the index, wrapping at 32 bits
    bus_req.write = item.write;
    bus_req.addr  = bases_ref[item.buf_sel] + 4 * cache_pkg::addr_t'(item.index);
    bus_req.data  = item.data;
    bus_req.id    = cache_pkg::req_id_t'(e);
    word          = bus_req.addr[`CACHE_ADDR_W-1:2];
    resp.write    = item.write;
    resp.id       = cache_pkg::req_id_t'(e);
    if (item.write) begin
      ref_mem[word] = item.data;
      resp.data     = '0;
    end else begin
      resp.data = ref_mem.exists(word) ? ref_mem[word] : fill_word(word);
    end
    exp_bus_q.push_back(bus_req);
    exp_q[e].push_back(resp);
    resp_order_q.push_back(cache_pkg::req_id_t'(e));
    accept_log.push_back(cache_pkg::req_id_t'(e));
  endtask

  // Engine driver, keeps valid up while its queue has work
  always @(posedge ap_clk) begin
    if (!control_areset) begin
      for (int e = 0; e < NUM_REQ; e++) begin
        if (req_valid[e] && req_ready[e]) begin
          record_accept(e, cur_item[e]);
        end
        if (!req_valid[e] || req_ready[e]) begin
          if (stim_q[e].size() > 0) begin
            cur_item[e]   = stim_q[e].pop_front();
            req_valid[e]  <= 1'b1;
            req_write[e]  <= cur_item[e].write;
            req_buffer[e] <= cur_item[e].buf_sel;
            req_index[e]  <= cur_item[e].index;
            req_data[e]   <= cur_item[e].data;
          end else begin
            req_valid[e] <= 1'b0;
          end
        end
      end
    end
  end

  // ------------------------------
  // Wishbone slave memory
  // ------------------------------
  always @(posedge ap_clk) begin
    logic [`CACHE_ADDR_W-3:0] key;
    key = wb_adr[`CACHE_ADDR_W-1:2];
    if (control_areset) begin
      wb_ack <= 1'b0;
    end else if (wb_ack) begin
      wb_ack <= 1'b0;
      // 0 to 3 wait states for the next cycle
      wait_left = $urandom_range(3, 0);
    end else if (wb_cyc && wb_stb) begin
      if (wait_left == 0) begin
        wb_ack <= 1'b1;
        if (wb_we) begin
          cache_mem[key] = wb_dat_w;
        end else begin
          wb_dat_r <= cache_mem.exists(key) ? cache_mem[key] : fill_word(key);
        end
      end else begin
        wait_left = wait_left - 1;
      end
    end
  end

  // Bus and response checks, away from the active edge
  always @(negedge ap_clk) begin
    cache_pkg::cache_request  exp_bus;
    cache_pkg::cache_response got;
    cache_pkg::req_id_t       owner;
    if (!control_areset) begin
      if (wb_cyc && wb_stb && wb_ack) begin
        if (exp_bus_q.size() == 0) begin
          report_failure($sformatf("%s: bus cycle without an accepted request", cur_test));
        end else begin
          exp_bus = exp_bus_q.pop_front();
          compare_address(cur_test, exp_bus.addr, wb_adr);
          if (wb_we !== exp_bus.write || wb_sel !== '1) begin
            report_failure($sformatf("MISMATCH %s expected we=%b sel=%h actual we=%b sel=%h",
                                     cur_test, exp_bus.write, {(`CACHE_DATA_W/8){1'b1}},
                                     wb_we, wb_sel));
          end
          if (exp_bus.write) begin
            compare_write_data(cur_test, exp_bus.data, wb_dat_w);
          end
        end
      end
      for (int e = 0; e < NUM_REQ; e++) begin
        if (resp_valid[e]) begin
          got.write = 1'b0;
          got.data  = resp_data;
          got.id    = cache_pkg::req_id_t'(e);
          if (resp_order_q.size() == 0) begin
            report_failure($sformatf("%s: engine %0d got a response it did not ask for",
                                     cur_test, e));
          end else begin
            // Oldest accepted request owns the next response
            owner = resp_order_q.pop_front();
            compare_response(cur_test, exp_q[owner].pop_front(), got);
          end
        end
      end
    end
  end

  // Hang guard
  always @(posedge ap_clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Run timed out after %0d cycles in test %s", TIMEOUT_CYCLES, cur_test);
      $display("SIMULATION FAILED");
      $fatal(1, "timeout");
    end
  end

  // ------------------------------
  // Sequencing helpers
  // ------------------------------
  function automatic bit drained();
    bit idle;
    idle = (req_valid == '0) && (exp_bus_q.size() == 0);
    for (int e = 0; e < NUM_REQ; e++) begin
      idle = idle && (stim_q[e].size() == 0) && (exp_q[e].size() == 0);
    end
    return idle;
  endfunction

  task automatic wait_drain();
    do begin
      @(negedge ap_clk);
    end while (!drained());
  endtask

  task automatic load_descriptor(input cache_pkg::buffer_bases bases);
    @(posedge ap_clk);
    bases_ref = bases;
    descriptor_valid <= 1'b1;
    descriptor_bases <= bases;
    @(posedge ap_clk);
    descriptor_valid <= 1'b0;
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------
  task automatic test_reset_state();
    cache_pkg::buffer_bases bases;
    cur_test = "reset_state";
    @(negedge ap_clk);
    if (req_ready !== '0 || resp_valid !== '0 || wb_cyc !== 1'b0 ||
        wb_stb !== 1'b0 || wb_we !== 1'b0) begin
      report_failure($sformatf({"MISMATCH reset_state expected ready=0 resp=0 cyc=0 stb=0",
                                " we=0 actual ready=%b resp=%b cyc=%b stb=%b we=%b"},
                               req_ready, resp_valid, wb_cyc, wb_stb, wb_we));
    end
    // Pending request must wait for a descriptor
    stim_q[0].push_back(make_req(1'b0, 2'd0, 16'h0003, '0));
    repeat (6) begin
      @(negedge ap_clk);
      if (req_ready !== '0 || wb_cyc !== 1'b0) begin
        report_failure($sformatf({"MISMATCH reset_state expected ready=0 cyc=0",
                                  " actual ready=%b cyc=%b"}, req_ready, wb_cyc));
      end
    end
    bases[0] = 32'h0010_0000;
    bases[1] = 32'h0020_0000;
    bases[2] = 32'h0030_0000;
    // Top of the map, wraps with large indices
    bases[3] = 32'hFFFF_0000;
    load_descriptor(bases);
    wait_drain();
  endtask

  task automatic test_address_map();
    cur_test = "address_map";
    for (int b = 0; b < `CACHE_NUM_BUF; b++) begin
      stim_q[0].push_back(make_req(1'b0, cache_pkg::buf_sel_t'(b),
                                   cache_pkg::index_t'(16 + 257 * b), '0));
    end
    stim_q[0].push_back(make_req(1'b0, 2'd3, 16'hFFFF, '0));
    wait_drain();
  endtask

  task automatic test_write_read();
    cur_test = "write_read";
    stim_q[0].push_back(make_req(1'b1, 2'd1, 16'h0022, 32'hDEAD_BEEF));
    stim_q[0].push_back(make_req(1'b0, 2'd1, 16'h0022, '0));
    stim_q[1].push_back(make_req(1'b1, 2'd2, 16'h0007, 32'h1234_5678));
    stim_q[1].push_back(make_req(1'b0, 2'd2, 16'h0007, '0));
    wait_drain();
  endtask

  task automatic test_alternation();
    cache_pkg::req_id_t next_id;
    cur_test = "alternation";
    accept_log.delete();
    for (int i = 0; i < 8; i++) begin
      stim_q[0].push_back(make_req(1'b0, 2'd0, cache_pkg::index_t'(i), '0));
      stim_q[1].push_back(make_req(1'b0, 2'd2, cache_pkg::index_t'(100 + i), '0));
    end
    wait_drain();
    for (int i = 1; i < accept_log.size(); i++) begin
      next_id = cache_pkg::req_id_t'((int'(accept_log[i-1]) + 1) % NUM_REQ);
      compare_owner(cur_test, next_id, accept_log[i]);
    end
  endtask

  // Small index range so reads hit earlier writes
  task automatic test_slow_ack();
    cur_test = "slow_ack";
    for (int e = 0; e < NUM_REQ; e++) begin
      for (int i = 0; i < 20; i++) begin
        stim_q[e].push_back(make_req($urandom_range(1, 0) == 1,
                                     cache_pkg::buf_sel_t'($urandom_range(3, 0)),
                                     cache_pkg::index_t'($urandom_range(15, 0)),
                                     $urandom()));
      end
    end
    wait_drain();
  endtask

  task automatic test_new_descriptor();
    cache_pkg::buffer_bases bases;
    cur_test = "new_descriptor";
    bases[0] = 32'h8000_0000;
    bases[1] = 32'h8100_0040;
    bases[2] = 32'h0000_1000;
    bases[3] = 32'h00FF_FFFC;
    load_descriptor(bases);
    for (int b = 0; b < `CACHE_NUM_BUF; b++) begin
      stim_q[1].push_back(make_req(1'b0, cache_pkg::buf_sel_t'(b),
                                   cache_pkg::index_t'(5 + b), '0));
    end
    wait_drain();
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    int unsigned seed_draw;
    seed_draw        = $urandom(92);
    control_areset   = 1'b1;
    descriptor_valid = 1'b0;
    descriptor_bases = '0;
    repeat (2) @(posedge ap_clk);
    control_areset <= 1'b0;
    test_reset_state();
    test_address_map();
    test_write_read();
    test_alternation();
    test_slow_ack();
    test_new_descriptor();
    if (error_count == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      $display("SIMULATION FAILED");
      $fatal(1, "errors were found");
    end
  end

endmodule

/* hw/cache_request_generator.sv */
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_request_generator (
  input  logic                                        ap_clk,
  input  logic                                        control_areset,
  // Descriptor
  input  logic                                        descriptor_valid,
  input  cache_pkg::buffer_bases                      descriptor_bases,
  // Engine requests
  input  logic [`CACHE_NUM_REQ-1:0]                   req_valid,
  input  logic [`CACHE_NUM_REQ-1:0]                   req_write,
  input  logic [`CACHE_NUM_REQ-1:0][`CACHE_BUF_W-1:0] req_buffer,
  input  logic [`CACHE_NUM_REQ-1:0][`CACHE_IDX_W-1:0] req_index,
  input  logic [`CACHE_NUM_REQ-1:0][`CACHE_DATA_W-1:0] req_data,
  output logic [`CACHE_NUM_REQ-1:0]                   req_ready,
  // Engine responses
  output logic [`CACHE_NUM_REQ-1:0]                   resp_valid,
  output logic [`CACHE_DATA_W-1:0]                    resp_data,
  // Wishbone classic master
  output logic                                        wb_cyc,
  output logic                                        wb_stb,
  output logic                                        wb_we,
  output logic [`CACHE_ADDR_W-1:0]                    wb_adr,
  output logic [`CACHE_DATA_W-1:0]                    wb_dat_w,
  output logic [`CACHE_DATA_W/8-1:0]                  wb_sel,
  input  logic [`CACHE_DATA_W-1:0]                    wb_dat_r,
  input  logic                                        wb_ack
);

  cache_pkg::engine_request eng_req [`CACHE_NUM_REQ];

  // ------------------------------
  // Internal streams
  // ------------------------------
  cache_req_if #(.payload_t(cache_pkg::engine_request)) arb_to_dec ();
  cache_req_if #(.payload_t(cache_pkg::cache_request))  dec_to_fifo ();
  cache_req_if #(.payload_t(cache_pkg::cache_request))  fifo_to_bus ();
  cache_req_if #(.payload_t(cache_pkg::cache_response)) bus_to_fifo ();
  cache_req_if #(.payload_t(cache_pkg::cache_response)) fifo_to_rtr ();

  // Engine ports into request structs
  for (genvar i = 0; i < `CACHE_NUM_REQ; i++) begin : g_pack
    assign eng_req[i].write   = req_write[i];
    assign eng_req[i].buf_sel = req_buffer[i];
    assign eng_req[i].index   = req_index[i];
    assign eng_req[i].data    = req_data[i];
    // Arbiter stamps the real owner
    assign eng_req[i].id      = '0;
  end

  // ------------------------------
  // Request path
  // ------------------------------
  request_arbiter u_arbiter (
    .ap_clk         (ap_clk),
    .control_areset (control_areset),
    .req_valid      (req_valid),
    .req_payload    (eng_req),
    .req_ready      (req_ready),
    .out            (arb_to_dec)
  );

  request_decode u_decode (
    .ap_clk           (ap_clk),
    .control_areset   (control_areset),
    .descriptor_valid (descriptor_valid),
    .descriptor_bases (descriptor_bases),
    .in               (arb_to_dec),
    .out              (dec_to_fifo)
  );

  sync_fifo #(
    .payload_t (cache_pkg::cache_request),
    .DEPTH     (`CACHE_REQ_FIFO_DEPTH)
  ) u_req_fifo (
    .ap_clk         (ap_clk),
    .control_areset (control_areset),
    .push           (dec_to_fifo),
    .pop            (fifo_to_bus)
  );

  // ------------------------------
  // Bus and response path
  // ------------------------------
  cache_bus_master u_bus_master (
    .ap_clk         (ap_clk),
    .control_areset (control_areset),
    .req            (fifo_to_bus),
    .resp           (bus_to_fifo),
    .wb_cyc         (wb_cyc),
    .wb_stb         (wb_stb),
    .wb_we          (wb_we),
    .wb_adr         (wb_adr),
    .wb_dat_w       (wb_dat_w),
    .wb_sel         (wb_sel),
    .wb_dat_r       (wb_dat_r),
    .wb_ack         (wb_ack)
  );

  sync_fifo #(
    .payload_t (cache_pkg::cache_response),
    .DEPTH     (`CACHE_RESP_FIFO_DEPTH)
  ) u_resp_fifo (
    .ap_clk         (ap_clk),
    .control_areset (control_areset),
    .push           (bus_to_fifo),
    .pop            (fifo_to_rtr)
  );

  response_router u_router (
    .ap_clk         (ap_clk),
    .control_areset (control_areset),
    .in             (fifo_to_rtr),
    .resp_valid     (resp_valid),
    .resp_data      (resp_data)
  );

endmodule

/* hw/response_router.sv */
`timescale 1ns/1ps
`include "cache_config.svh"

module response_router (
  input  logic                      ap_clk,
  input  logic                      control_areset,
  cache_req_if.sink                 in,
  output logic [`CACHE_NUM_REQ-1:0] resp_valid,
  output logic [`CACHE_DATA_W-1:0]  resp_data
);

  localparam int NUM_REQ = `CACHE_NUM_REQ;

  // Engines take every pulse, so no back-pressure
  assign in.ready = 1'b1;

  // ------------------------------
  // One-hot valid pulse
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      resp_valid <= '0;
    end else begin
      for (int i = 0; i < NUM_REQ; i++) begin
        // Owner decoded from the id
        resp_valid[i] <= in.valid && (in.payload.id == cache_pkg::req_id_t'(i));
      end
    end
  end

  // Data alongside, meaningful only with a pulse
  always_ff @(posedge ap_clk) begin
    if (in.valid) begin
      resp_data <= in.payload.data;
    end
  end

endmodule

/* hw/cache_bus_master.sv */
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_bus_master (
  input  logic                        ap_clk,
  input  logic                        control_areset,
  cache_req_if.sink                   req,
  cache_req_if.source                 resp,
  output logic                        wb_cyc,
  output logic                        wb_stb,
  output logic                        wb_we,
  output logic [`CACHE_ADDR_W-1:0]    wb_adr,
  output logic [`CACHE_DATA_W-1:0]    wb_dat_w,
  output logic [`CACHE_DATA_W/8-1:0]  wb_sel,
  input  logic [`CACHE_DATA_W-1:0]    wb_dat_r,
  input  logic                        wb_ack
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BUS,
    ST_RESP
  } state_t;

  state_t                  state;
  // Request in flight on the bus
  cache_pkg::cache_request req_q;

  // ------------------------------
  // Request side
  // ------------------------------
  // Pop only with room for the response
  assign req.ready = (state == ST_IDLE) && resp.ready;

  always_ff @(posedge ap_clk) begin
    if (req.valid && req.ready) begin
      req_q <= req.payload;
    end
  end

  // ------------------------------
  // FSM
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (req.valid && req.ready) begin
            state <= ST_BUS;
          end
        end
        // Hold the classic cycle until ack
        ST_BUS: begin
          if (wb_ack) begin
            state <= ST_RESP;
          end
        end
        // Bus released for one cycle
        ST_RESP: begin
          state <= ST_IDLE;
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // ------------------------------
  // Wishbone outputs
  // ------------------------------
  assign wb_cyc   = (state == ST_BUS);
  assign wb_stb   = (state == ST_BUS);
  assign wb_we    = (state == ST_BUS) && req_q.write;
  assign wb_adr   = req_q.addr;
  assign wb_dat_w = req_q.data;
  // Always whole words
  assign wb_sel   = '1;

  // ------------------------------
  // Response, pushed on the ack cycle
  // ------------------------------
  // Room was checked before the pop, so ready holds
  assign resp.valid         = (state == ST_BUS) && wb_ack;
  assign resp.payload.write = req_q.write;
  // Writes return zero
  assign resp.payload.data  = req_q.write ? '0 : wb_dat_r;
  assign resp.payload.id    = req_q.id;

endmodule

/* hw/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 4
) (
  input  logic        ap_clk,
  input  logic        control_areset,
  cache_req_if.sink   push,
  cache_req_if.source pop
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Storage, no reset on payload
  payload_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  // ------------------------------
  // Handshakes
  // ------------------------------
  // Full at DEPTH entries
  assign push.ready = (count != CNT_W'(DEPTH));
  assign pop.valid  = (count != '0);
  // Show-ahead, head entry always on the read side
  assign pop.payload = mem[rd_ptr];

  assign do_push = push.valid && push.ready;
  assign do_pop  = pop.valid && pop.ready;

  always_ff @(posedge ap_clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push.payload;
    end
  end

  // ------------------------------
  // Pointers and occupancy
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leave count alone
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

/* hw/request_decode.sv */
`timescale 1ns/1ps

module request_decode (
  input  logic                   ap_clk,
  input  logic                   control_areset,
  input  logic                   descriptor_valid,
  input  cache_pkg::buffer_bases descriptor_bases,
  cache_req_if.sink              in,
  cache_req_if.source            out
);

  // Registered descriptor copy
  cache_pkg::buffer_bases bases_q;
  logic                   desc_loaded;

  // One-entry output stage
  logic                    out_valid_q;
  cache_pkg::cache_request dec_q;
  cache_pkg::addr_t        base_sel;
  cache_pkg::addr_t        word_offset;

  // ------------------------------
  // Descriptor
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      desc_loaded <= 1'b0;
    end else if (descriptor_valid) begin
      desc_loaded <= 1'b1;
    end
  end

  // Bases follow each new descriptor, one cycle later
  always_ff @(posedge ap_clk) begin
    if (descriptor_valid) begin
      bases_q <= descriptor_bases;
    end
  end

  // ------------------------------
  // Address translation
  // ------------------------------
  assign base_sel    = bases_q[in.payload.buf_sel];
  // Word index to byte offset
  assign word_offset = cache_pkg::addr_t'(in.payload.index) << 2;

  // Stall until bases exist, else take when empty or draining
  assign in.ready = desc_loaded && (!out_valid_q || out.ready);

  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      out_valid_q <= 1'b0;
    end else if (in.valid && in.ready) begin
      out_valid_q <= 1'b1;
    end else if (out.ready) begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (in.valid && in.ready) begin
      dec_q.write <= in.payload.write;
      // Wraps modulo the address width
      dec_q.addr  <= base_sel + word_offset;
      dec_q.data  <= in.payload.data;
      dec_q.id    <= in.payload.id;
    end
  end

  assign out.valid   = out_valid_q;
  assign out.payload = dec_q;

endmodule

/* hw/request_arbiter.sv */
`timescale 1ns/1ps
`include "cache_config.svh"

module request_arbiter (
  input  logic                      ap_clk,
  input  logic                      control_areset,
  input  logic [`CACHE_NUM_REQ-1:0] req_valid,
  input  cache_pkg::engine_request  req_payload [`CACHE_NUM_REQ],
  output logic [`CACHE_NUM_REQ-1:0] req_ready,
  cache_req_if.source               out
);

  localparam int NUM_REQ = `CACHE_NUM_REQ;

  // Engine with first claim this cycle
  cache_pkg::req_id_t rr_ptr;
  cache_pkg::req_id_t pick;
  logic               pick_found;
  // Grant frozen while the output stalls
  logic               locked;
  cache_pkg::req_id_t lock_id;
  cache_pkg::req_id_t grant_id;

  // ------------------------------
  // Round-robin search
  // ------------------------------
  always_comb begin
    int cand;
    pick = rr_ptr;
    pick_found = 1'b0;
    for (int i = 0; i < NUM_REQ; i++) begin
      cand = int'(rr_ptr) + i;
      if (cand >= NUM_REQ) begin
        cand = cand - NUM_REQ;
      end
      if (!pick_found && req_valid[cand]) begin
        pick = cache_pkg::req_id_t'(cand);
        pick_found = 1'b1;
      end
    end
  end

  assign grant_id  = locked ? lock_id : pick;
  assign out.valid = locked | pick_found;

  // Stamp the owner into the payload
  always_comb begin
    out.payload = req_payload[grant_id];
    out.payload.id = grant_id;
  end

  // Only the transferring engine sees ready
  always_comb begin
    for (int i = 0; i < NUM_REQ; i++) begin
      req_ready[i] = out.valid && out.ready && (grant_id == cache_pkg::req_id_t'(i));
    end
  end

  // ------------------------------
  // Pointer and lock
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      rr_ptr  <= '0;
      locked  <= 1'b0;
      lock_id <= '0;
    end else if (out.valid && out.ready) begin
      // Next engine after the granted one
      rr_ptr <= (grant_id == cache_pkg::req_id_t'(NUM_REQ - 1)) ? '0 : grant_id + 1'b1;
      locked <= 1'b0;
    end else if (out.valid) begin
      locked  <= 1'b1;
      lock_id <= grant_id;
    end
  end

endmodule

/* hw/cache_req_if.sv */
`timescale 1ns/1ps

// Valid/ready stream of one payload
interface cache_req_if #(
  parameter type payload_t = logic
) ();

  logic     valid;
  logic     ready;
  payload_t payload;

  // Producer side
  modport source (
    output valid,
    output payload,
    input  ready
  );

  // Consumer side
  modport sink (
    input  valid,
    input  payload,
    output ready
  );

endinterface

/* hw/cache_pkg.sv */
`include "cache_config.svh"

package cache_pkg;

  // ------------------------------
  // Field types
  // ------------------------------
  typedef logic [`CACHE_ADDR_W-1:0] addr_t;
  typedef logic [`CACHE_DATA_W-1:0] data_t;
  typedef logic [`CACHE_IDX_W-1:0] index_t;
  typedef logic [`CACHE_BUF_W-1:0] buf_sel_t;
  typedef logic [`CACHE_ID_W-1:0] req_id_t;

  // ------------------------------
  // Stream payloads
  // ------------------------------
  // Word request as an engine issues it
  typedef struct packed {
    logic     write;
    buf_sel_t buf_sel;
    index_t   index;
    data_t    data;
    req_id_t  id;
  } engine_request;

  // After translation to a byte address
  typedef struct packed {
    logic    write;
    addr_t   addr;
    data_t   data;
    req_id_t id;
  } cache_request;

  // Read data, zero for writes
  typedef struct packed {
    logic    write;
    data_t   data;
    req_id_t id;
  } cache_response;

  // Base byte address per buffer, index is the buffer select
  typedef addr_t [`CACHE_NUM_BUF-1:0] buffer_bases;

endpackage

/* hw/cache_config.svh */
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// Graph engines sharing the cache
`define CACHE_NUM_REQ 2
// Id field wide enough for every engine
`define CACHE_ID_W 1

// Byte address and word widths
`define CACHE_ADDR_W 32
`define CACHE_DATA_W 32

// Vertex, edge, in-degree, out-degree arrays
`define CACHE_NUM_BUF 4
`define CACHE_BUF_W 2

// Word index into one buffer
`define CACHE_IDX_W 16

// Queue depths
`define CACHE_REQ_FIFO_DEPTH 8
`define CACHE_RESP_FIFO_DEPTH 4

`endif
